/* mango_pkg.sv */
package mango_pkg;

	localparam logic [31:0] reset_pc = 32'h0000_0000;

	localparam logic [5:0] op_special = 6'h00;
	localparam logic [5:0] op_beq     = 6'h04;
	localparam logic [5:0] op_bne     = 6'h05;
	localparam logic [5:0] op_addiu   = 6'h09;
	localparam logic [5:0] op_ori     = 6'h0d;
	localparam logic [5:0] op_lui     = 6'h0f;
	localparam logic [5:0] op_lw      = 6'h23;
	localparam logic [5:0] op_lbu     = 6'h24;
	localparam logic [5:0] op_sb      = 6'h28;
	localparam logic [5:0] op_sw      = 6'h2b;

	localparam logic [5:0] fn_addu = 6'h21;
	localparam logic [5:0] fn_subu = 6'h23;
	localparam logic [5:0] fn_and  = 6'h24;
	localparam logic [5:0] fn_or   = 6'h25;
	localparam logic [5:0] fn_slt  = 6'h2a;

	typedef struct packed {
		logic [5:0]  op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [4:0]  shamt;
		logic [5:0]  funct;
	} r_fields_t;

	typedef struct packed {
		logic [5:0]  op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_fields_t;

	typedef union packed {
		r_fields_t r;
		i_fields_t i;
	} inst_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt,
		alu_lui
	} alu_op_t;

	typedef struct packed {
		alu_op_t    alu_op;
		logic       use_imm;     // b operand from imm_ext.
		logic       zero_ext;
		logic       reg_write;
		logic [4:0] dest;
		logic       is_load;
		logic       is_store;
		logic       byte_access;
		logic       is_beq;
		logic       is_bne;
		logic       illegal;
	} dec_t;

	typedef struct packed {
		logic        en;
		logic [3:0]  wen;
		logic [31:0] addr;
		logic [31:0] wdata;
	} bus_req_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [3:0]  wen;
		logic [4:0]  wnum;
		logic [31:0] wdata;
	} wb_info_t;

endpackage

/* mango_alu.sv */
`timescale 1ns/1ns

module mango_alu (
	input  mango_pkg::alu_op_t op,
	input  logic [31:0]        a,
	input  logic [31:0]        b,
	output logic [31:0]        result,
	output logic               equal
);
	import mango_pkg::*;

	logic [31:0] sum;
	logic [31:0] diff;
	logic        less;

	assign sum  = a + b;
	assign diff = a - b;
	assign less = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			alu_add: result = sum;
			alu_sub: result = diff;
			alu_and: result = a & b;
			alu_or:  result = a | b;
			alu_slt: result = {31'h0, less};
			alu_lui: result = {b[15:0], 16'h0000};
			default: result = sum;
		endcase
	end

	// beq and bne compare rs with rt.
	assign equal = a == b;

endmodule

/* mango_decode.sv */
`timescale 1ns/1ns

module mango_decode (
	input  mango_pkg::inst_t inst,
	output mango_pkg::dec_t  dec,
	output logic [31:0]      imm_ext
);
	import mango_pkg::*;

	always_comb begin
		dec        = '0;
		dec.alu_op = alu_add;
		dec.dest   = inst.i.rt;
		case (inst.i.op)
			op_special: begin
				dec.dest      = inst.r.rd;
				dec.reg_write = 1'b1;
				case (inst.r.funct)
					fn_addu: dec.alu_op = alu_add;
					fn_subu: dec.alu_op = alu_sub;
					fn_and:  dec.alu_op = alu_and;
					fn_or:   dec.alu_op = alu_or;
					fn_slt:  dec.alu_op = alu_slt;
					default: dec.illegal = 1'b1;
				endcase
				if (inst.r.shamt != 5'd0)
					dec.illegal = 1'b1;   // shamt must be zero for these.
				if (dec.illegal)
					dec.reg_write = 1'b0;
			end
			op_addiu: begin
				dec.use_imm   = 1'b1;
				dec.reg_write = 1'b1;
			end
			op_ori: begin
				dec.alu_op    = alu_or;
				dec.use_imm   = 1'b1;
				dec.zero_ext  = 1'b1;
				dec.reg_write = 1'b1;
			end
			op_lui: begin
				dec.alu_op    = alu_lui;
				dec.use_imm   = 1'b1;
				dec.zero_ext  = 1'b1;
				dec.reg_write = 1'b1;
			end
			op_lw, op_lbu: begin
				dec.use_imm     = 1'b1;
				dec.reg_write   = 1'b1;
				dec.is_load     = 1'b1;
				dec.byte_access = inst.i.op == op_lbu;
			end
			op_sw, op_sb: begin
				dec.use_imm     = 1'b1;
				dec.is_store    = 1'b1;
				dec.byte_access = inst.i.op == op_sb;
			end
			op_beq: dec.is_beq = 1'b1;
			op_bne: dec.is_bne = 1'b1;
			default: dec.illegal = 1'b1;   // runs as a no-op.
		endcase
	end

	// branch offsets and addresses sign-extend, logic immediates do not.
	assign imm_ext = dec.zero_ext ? {16'h0000, inst.i.imm} : {{16{inst.i.imm[15]}}, inst.i.imm};

endmodule

/* mango_regfile.sv */
`timescale 1ns/1ns

module mango_regfile (
	input  logic        clk,
	input  logic        resetn,
	input  logic [4:0]  raddr_a,
	input  logic [4:0]  raddr_b,
	output logic [31:0] rdata_a,
	output logic [31:0] rdata_b,
	input  logic        we,
	input  logic [4:0]  waddr,
	input  logic [31:0] wdata
);

	logic [31:0] regs [1:31];   // no storage for r0.

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= 32'h0;
		end else if (we && waddr != 5'd0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata_a = (raddr_a == 5'd0) ? 32'h0 : regs[raddr_a];
	assign rdata_b = (raddr_b == 5'd0) ? 32'h0 : regs[raddr_b];

endmodule

/* mango_lsu.sv */
`timescale 1ns/1ns

module mango_lsu (
	input  logic [31:0] addr,
	input  logic [31:0] store_data,
	input  logic        byte_access,
	input  logic        is_store,
	output logic [3:0]  wen,
	output logic [31:0] wdata,
	input  logic [31:0] load_raw,
	output logic [31:0] load_data
);

	logic [1:0] lane;
	logic [7:0] load_byte;

	assign lane = addr[1:0];

	always_comb begin
		if (!is_store)
			wen = 4'h0;
		else if (byte_access)
			wen = 4'b0001 << lane;   // little endian lanes.
		else
			wen = 4'hf;
	end

	assign wdata = byte_access ? {4{store_data[7:0]}} : store_data;

	always_comb begin
		case (lane)
			2'd0: load_byte = load_raw[7:0];
			2'd1: load_byte = load_raw[15:8];
			2'd2: load_byte = load_raw[23:16];
			default: load_byte = load_raw[31:24];
		endcase
	end

	assign load_data = byte_access ? {24'h000000, load_byte} : load_raw;

endmodule

/* mango_core.sv */
`timescale 1ns/1ns

module mango_core (
	input  logic                clk,
	input  logic                resetn,
	output mango_pkg::bus_req_t ibus,
	input  logic [31:0]         ibus_rdata,
	input  logic                ibus_streq,
	output mango_pkg::bus_req_t dbus,
	input  logic [31:0]         dbus_rdata,
	input  logic                dbus_streq,
	output mango_pkg::wb_info_t wb
);
	import mango_pkg::*;

	typedef enum logic [1:0] {ph_boot, ph_fetch, ph_exec, ph_mem} phase_t;

	phase_t      phase;
	logic [31:0] pc;
	inst_t       ir;
	dec_t        dec;
	logic [31:0] imm_ext;
	logic [31:0] rs_val;
	logic [31:0] rt_val;
	logic [31:0] alu_result;
	logic        equal;
	logic        taken;
	logic [31:0] pc_plus4;
	logic [31:0] next_pc;
	logic        mem_load;
	logic        mem_store;
	logic        mem_byte;
	logic [31:0] mem_addr;
	logic [31:0] mem_data;
	logic [3:0]  st_wen;
	logic [31:0] st_wdata;
	logic [31:0] load_data;
	logic        exec_wb;
	logic        mem_wb;
	logic        rf_we;
	logic [4:0]  rf_waddr;
	logic [31:0] rf_wdata;

	mango_decode decode (.inst(ir), .dec(dec), .imm_ext(imm_ext));

	mango_regfile regfile (
		.clk     (clk),
		.resetn  (resetn),
		.raddr_a (ir.i.rs),
		.raddr_b (ir.i.rt),
		.rdata_a (rs_val),
		.rdata_b (rt_val),
		.we      (rf_we),
		.waddr   (rf_waddr),
		.wdata   (rf_wdata)
	);

	mango_alu alu (
		.op     (dec.alu_op),
		.a      (rs_val),
		.b      (dec.use_imm ? imm_ext : rt_val),
		.result (alu_result),
		.equal  (equal)
	);

	mango_lsu lsu (
		.addr        (mem_addr),
		.store_data  (mem_data),
		.byte_access (mem_byte),
		.is_store    (mem_store && phase == ph_mem),
		.wen         (st_wen),
		.wdata       (st_wdata),
		.load_raw    (dbus_rdata),
		.load_data   (load_data)
	);

	assign pc_plus4 = pc + 32'd4;
	assign taken    = (dec.is_beq && equal) || (dec.is_bne && !equal);
	assign next_pc  = taken ? pc_plus4 + {imm_ext[29:0], 2'b00} : pc_plus4;

	assign exec_wb  = phase == ph_exec && dec.reg_write && !dec.is_load && !dec.illegal;
	assign mem_wb   = phase == ph_mem && mem_load && !dbus_streq;  // last memory cycle.
	assign rf_we    = exec_wb || mem_wb;
	assign rf_waddr = dec.dest;
	assign rf_wdata = mem_wb ? load_data : alu_result;

	assign wb.pc    = pc;
	assign wb.wen   = (rf_we && rf_waddr != 5'd0) ? 4'hf : 4'h0;
	assign wb.wnum  = rf_waddr;
	assign wb.wdata = rf_wdata;

	assign ibus.en    = phase == ph_fetch;
	assign ibus.wen   = 4'h0;
	assign ibus.addr  = pc;
	assign ibus.wdata = 32'h0;

	assign dbus.en    = phase == ph_mem;
	assign dbus.wen   = st_wen;
	assign dbus.addr  = mem_addr;
	assign dbus.wdata = st_wdata;

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			phase     <= ph_boot;
			pc        <= reset_pc;
			mem_load  <= 1'b0;
			mem_store <= 1'b0;
			mem_byte  <= 1'b0;
		end else begin
			case (phase)
				ph_boot: phase <= ph_fetch;
				ph_fetch: if (!ibus_streq) phase <= ph_exec;
				ph_exec: begin
					if (dec.is_load || dec.is_store) begin
						phase     <= ph_mem;
						mem_load  <= dec.is_load;
						mem_store <= dec.is_store;
						mem_byte  <= dec.byte_access;
					end else begin
						phase <= ph_fetch;
						pc    <= next_pc;
					end
				end
				default: begin
					if (!dbus_streq) begin
						phase <= ph_fetch;
						pc    <= pc_plus4;   // loads and stores never branch.
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (phase == ph_fetch && !ibus_streq)
			ir <= ibus_rdata;
		if (phase == ph_exec) begin
			mem_addr <= alu_result;
			mem_data <= rt_val;
		end
	end

endmodule

/* mycpu_top.sv */
`timescale 1ns/1ns

module mycpu_top (
	input  logic        clk,
	input  logic        resetn,

	input  logic [31:0] inst_sram_rdata,
	output logic        inst_sram_en,
	output logic [3:0]  inst_sram_wen,
	output logic [31:0] inst_sram_addr,
	output logic [31:0] inst_sram_wdata,

	input  logic [31:0] data_sram_rdata,
	output logic        data_sram_en,
	output logic [3:0]  data_sram_wen,
	output logic [31:0] data_sram_addr,
	output logic [31:0] data_sram_wdata,

	output logic [31:0] debug_wb_pc,
	output logic [3:0]  debug_wb_rf_wen,
	output logic [4:0]  debug_wb_rf_wnum,
	output logic [31:0] debug_wb_rf_wdata
);
	import mango_pkg::*;

	bus_req_t ibus;
	bus_req_t dbus;
	wb_info_t wb;
	logic     ibus_streq;
	logic     dbus_streq;
	logic     istate;    // set while read data of the ibus access is in flight.
	logic     dstate;

	mango_core core (
		.clk        (clk),
		.resetn     (resetn),
		.ibus       (ibus),
		.ibus_rdata (inst_sram_rdata),
		.ibus_streq (ibus_streq),
		.dbus       (dbus),
		.dbus_rdata (data_sram_rdata),
		.dbus_streq (dbus_streq),
		.wb         (wb)
	);

	assign inst_sram_en    = ibus.en;
	assign inst_sram_wen   = 4'h0;
	assign inst_sram_addr  = ibus.addr;
	assign inst_sram_wdata = 32'h0;

	assign data_sram_en    = dbus.en;
	assign data_sram_wen   = dbus.wen;
	assign data_sram_addr  = dbus.addr;
	assign data_sram_wdata = dbus.wdata;

	assign debug_wb_pc       = wb.pc;
	assign debug_wb_rf_wen   = wb.wen;
	assign debug_wb_rf_wnum  = wb.wnum;
	assign debug_wb_rf_wdata = wb.wdata;

	// sram data lags the address by one clock, so stall the first cycle.
	assign ibus_streq = ibus.en && !istate;
	assign dbus_streq = dbus.en && !dstate;

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			istate <= 1'b0;
			dstate <= 1'b0;
		end else begin
			istate <= ibus.en && !istate;
			dstate <= dbus.en && !dstate;
		end
	end

endmodule

/* mycpu_checker.sv */
`timescale 1ns/1ns

module mycpu_checker (
	input logic        clk,
	input logic        resetn,
	input logic        inst_sram_en,
	input logic [3:0]  inst_sram_wen,
	input logic [31:0] inst_sram_addr,
	input logic        data_sram_en,
	input logic [3:0]  data_sram_wen,
	input logic [31:0] data_sram_addr,
	input logic [31:0] data_sram_wdata,
	input logic        ibus_streq,
	input logic        dbus_streq,
	input logic [3:0]  debug_wb_rf_wen,
	input logic [4:0]  debug_wb_rf_wnum
);

	int fail_count = 0;

	inst_wen_zero: assert property (@(posedge clk) inst_sram_wen == 4'h0)
		else begin
			$error("instruction port write enable is set");
			fail_count++;
		end

	reset_quiet: assert property (@(posedge clk) !resetn |-> !inst_sram_en && !data_sram_en)
		else begin
			$error("bus enable high during reset");
			fail_count++;
		end

	// request must hold through the stall cycle.
	ibus_hold: assert property (@(posedge clk) disable iff (!resetn)
		ibus_streq |=> inst_sram_en && $stable(inst_sram_addr))
		else begin
			$error("instruction request changed while stalled");
			fail_count++;
		end

	dbus_hold: assert property (@(posedge clk) disable iff (!resetn)
		dbus_streq |=> data_sram_en && $stable(data_sram_addr) &&
			$stable(data_sram_wdata) && $stable(data_sram_wen))
		else begin
			$error("data request changed while stalled");
			fail_count++;
		end

	wb_nonzero: assert property (@(posedge clk) disable iff (!resetn)
		debug_wb_rf_wen != 4'h0 |-> debug_wb_rf_wnum != 5'd0)
		else begin
			$error("debug write reports register zero");
			fail_count++;
		end

endmodule

bind mycpu_top mycpu_checker chk (
	.clk              (clk),
	.resetn           (resetn),
	.inst_sram_en     (inst_sram_en),
	.inst_sram_wen    (inst_sram_wen),
	.inst_sram_addr   (inst_sram_addr),
	.data_sram_en     (data_sram_en),
	.data_sram_wen    (data_sram_wen),
	.data_sram_addr   (data_sram_addr),
	.data_sram_wdata  (data_sram_wdata),
	.ibus_streq       (ibus_streq),
	.dbus_streq       (dbus_streq),
	.debug_wb_rf_wen  (debug_wb_rf_wen),
	.debug_wb_rf_wnum (debug_wb_rf_wnum)
);

/* tb_mycpu.sv */
`timescale 1ns/1ns

module tb_mycpu;
	import mango_pkg::*;

	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic [4:0]  wnum;
		logic [31:0] wdata;
	} wb_rec_t;

	logic        clk;
	logic        resetn;
	logic [31:0] inst_sram_rdata = 32'h0;
	logic [31:0] data_sram_rdata = 32'h0;
	logic        inst_sram_en, data_sram_en;
	logic [3:0]  inst_sram_wen, data_sram_wen, debug_wb_rf_wen;
	logic [31:0] inst_sram_addr, inst_sram_wdata, data_sram_addr, data_sram_wdata;
	logic [31:0] debug_wb_pc, debug_wb_rf_wdata;
	logic [4:0]  debug_wb_rf_wnum;

	logic [31:0] imem [0:255];
	logic [31:0] dmem [0:255];
	logic [31:0] ref_dmem [0:255];
	logic [31:0] ref_regs [0:31];
	logic [31:0] ref_pc;
	logic [31:0] vals [0:3];
	logic [31:0] i_addr_q = 32'h0;
	logic [31:0] d_addr_q = 32'h0;
	wb_rec_t     exp_q [$];
	logic [7:0]  touched [$];   // data words written by stores.
	int          prog_len = 0;
	int          n_exec = 0;
	int          total = 0;
	int          compared = 0;
	int          errors = 0;
	int          timeouts = 0;
	int          cycles = 0;
	int          limit = 0;
	int          total_errs = 0;
	logic        fetch_seen = 1'b0;
	logic        done = 1'b0;

	mycpu_top UUT (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// sram models answer one clock after the enabled edge.
	always @(posedge clk) begin
		if (inst_sram_en)
			i_addr_q <= inst_sram_addr;
		if (data_sram_en) begin
			d_addr_q <= data_sram_addr;
			if (data_sram_wen[0]) dmem[data_sram_addr[9:2]][7:0] <= data_sram_wdata[7:0];
			if (data_sram_wen[1]) dmem[data_sram_addr[9:2]][15:8] <= data_sram_wdata[15:8];
			if (data_sram_wen[2]) dmem[data_sram_addr[9:2]][23:16] <= data_sram_wdata[23:16];
			if (data_sram_wen[3]) dmem[data_sram_addr[9:2]][31:24] <= data_sram_wdata[31:24];
		end
	end

	always @(negedge clk) begin
		inst_sram_rdata <= imem[i_addr_q[9:2]];
		data_sram_rdata <= dmem[d_addr_q[9:2]];
	end

	function automatic logic [31:0] enc_r(logic [5:0] fn, int rs, int rt, int rd);
		return {op_special, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
	endfunction

	function automatic logic [31:0] enc_i(logic [5:0] op, int rs, int rt, int imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	task automatic put(logic [31:0] w);
		imem[prog_len[7:0]] = w;
		prog_len++;
	endtask

	task automatic load_value(int r, logic [31:0] v);
		put(enc_i(op_lui, 0, r, int'(v[31:16])));
		put(enc_i(op_ori, r, r, int'(v[15:0])));
	endtask

	// one instruction of the isa model; valid is set for a write to a nonzero register.
	function automatic wb_rec_t ref_step();
		logic [31:0] ins, a, b, simm, zimm, res, npc, addr, shifted;
		logic [5:0]  op, fn;
		logic [4:0]  rt, rd, sh, dst;
		logic        wr;
		wb_rec_t     e;
		ins = imem[ref_pc[9:2]];
		op = ins[31:26];
		rt = ins[20:16];
		rd = ins[15:11];
		sh = ins[10:6];
		fn = ins[5:0];
		a = ref_regs[ins[25:21]];
		b = ref_regs[rt];
		simm = {{16{ins[15]}}, ins[15:0]};
		zimm = {16'h0000, ins[15:0]};
		addr = a + simm;
		npc = ref_pc + 32'd4;
		shifted = ref_dmem[addr[9:2]] >> {addr[1:0], 3'b000};
		wr = 1'b1;
		dst = rt;
		res = 32'h0;
		case (op)
			op_special: begin
				dst = rd;
				wr = sh == 5'd0;
				case (fn)
					fn_addu: res = a + b;
					fn_subu: res = a - b;
					fn_and:  res = a & b;
					fn_or:   res = a | b;
					fn_slt:  res = {31'h0, $signed(a) < $signed(b)};
					default: wr = 1'b0;
				endcase
			end
			op_addiu: res = a + simm;
			op_ori:   res = a | zimm;
			op_lui:   res = {ins[15:0], 16'h0000};
			op_lw:    res = ref_dmem[addr[9:2]];
			op_lbu:   res = {24'h000000, shifted[7:0]};
			op_sw, op_sb: begin
				wr = 1'b0;
				if (op == op_sw)
					ref_dmem[addr[9:2]] = b;
				else
					ref_dmem[addr[9:2]][{addr[1:0], 3'b000} +: 8] = b[7:0];
				touched.push_back(addr[9:2]);
			end
			op_beq, op_bne: begin
				wr = 1'b0;
				if ((a == b) == (op == op_beq))
					npc = npc + {simm[29:0], 2'b00};
			end
			default: wr = 1'b0;
		endcase
		e = '0;
		e.pc = ref_pc;
		if (wr && dst != 5'd0) begin
			ref_regs[dst] = res;
			e.valid = 1'b1;
			e.wnum = dst;
			e.wdata = res;
		end
		ref_pc = npc;
		return e;
	endfunction

	task automatic build_program();
		wb_rec_t rec;
		imem = '{default: 32'h0};   // zero words decode as no-ops.
		for (int i = 0; i < 256; i++)
			dmem[i[7:0]] = 32'hd47a_0000 ^ {16'h0000, ~i[7:0], i[7:0]};
		ref_dmem = dmem;
		vals[0] = $urandom();
		vals[1] = $urandom();
		vals[2] = $urandom() | 32'h8000_0000;
		vals[3] = $urandom();
		for (int r = 0; r < 4; r++)
			load_value(r + 1, vals[r[1:0]]);
		put(enc_r(fn_addu, 1, 2, 5));
		put(enc_r(fn_subu, 1, 2, 6));
		put(enc_r(fn_and, 1, 3, 7));
		put(enc_r(fn_or, 2, 4, 8));
		put(enc_r(fn_slt, 1, 3, 9));
		put(enc_r(fn_slt, 3, 1, 10));
		put(enc_r(fn_addu, 1, 2, 0));   // r0 stays zero.
		put(enc_i(op_addiu, 1, 11, -5));
		put(enc_i(op_addiu, 0, 12, -32768));
		put(enc_i(op_ori, 0, 13, 32'h8001));
		put(enc_i(op_ori, 0, 14, 32'h40));
		put(enc_i(op_sw, 14, 1, 0));
		put(enc_i(op_lw, 14, 15, 0));
		for (int k = 0; k < 4; k++)
			put(enc_i(op_sb, 14, k + 1, 4 + k));
		for (int k = 0; k < 4; k++)
			put(enc_i(op_lbu, 14, 16 + k, 4 + k));
		put(enc_i(op_sw, 14, 2, 8));
		put(enc_i(op_sb, 14, 3, 9));
		put(enc_i(op_lw, 14, 20, 8));
		put(enc_i(op_lw, 14, 21, 4));
		put(enc_i(op_addiu, 0, 22, 3));
		put(enc_i(op_addiu, 0, 23, 0));
		put(enc_r(fn_addu, 23, 1, 23));
		put(enc_i(op_addiu, 22, 22, -1));
		put(enc_i(op_bne, 22, 0, -3));   // back to the addu for three passes.
		put(enc_i(op_beq, 1, 2, 1));
		put(enc_i(op_addiu, 0, 24, 7));
		put(enc_i(op_beq, 0, 0, 1));
		put(enc_i(op_addiu, 0, 25, 9));
		put(enc_i(op_bne, 0, 0, 1));
		put(enc_i(op_addiu, 0, 26, 11));
		put(enc_i(op_bne, 1, 0, 1));
		put(enc_i(op_addiu, 0, 27, 13));
		put(enc_i(op_sw, 14, 23, 12));
		put(enc_i(op_lw, 14, 28, 12));   // last write-back follows every store.
		ref_pc = reset_pc;
		ref_regs = '{default: 32'h0};
		while (ref_pc != 32'(prog_len) * 32'd4 && n_exec < 1000) begin
			rec = ref_step();
			n_exec++;
			if (rec.valid)
				exp_q.push_back(rec);
		end
		total = exp_q.size();
	endtask

	task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("MISMATCH %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic check_memory();
		foreach (touched[k])
			check($sformatf("dmem word %0d", touched[k]), ref_dmem[touched[k]], dmem[touched[k]]);
	endtask

	initial begin : compare
		wb_rec_t rec;
		forever begin
			@(posedge clk);
			if (!resetn) begin
				check("reset inst_sram_en", 32'h0, 32'(inst_sram_en));
				check("reset data_sram_en", 32'h0, 32'(data_sram_en));
				check("reset debug_wb_rf_wen", 32'h0, 32'(debug_wb_rf_wen));
			end else begin
				check("inst_sram_wdata", 32'h0, inst_sram_wdata);
				if (inst_sram_en && !fetch_seen) begin
					fetch_seen = 1'b1;
					check("first fetch address", reset_pc, inst_sram_addr);
				end
				if (debug_wb_rf_wen != 4'h0) begin
					if (exp_q.size() == 0) begin
						errors++;
						$display("unexpected register write to r%0d at pc %h",
							debug_wb_rf_wnum, debug_wb_pc);
					end else begin
						rec = exp_q.pop_front();
						check($sformatf("wb %0d pc", compared), rec.pc, debug_wb_pc);
						check($sformatf("wb %0d wen", compared), 32'hf, 32'(debug_wb_rf_wen));
						check($sformatf("wb %0d wnum", compared), 32'(rec.wnum),
							32'(debug_wb_rf_wnum));
						check($sformatf("wb %0d wdata", compared), rec.wdata, debug_wb_rf_wdata);
						compared++;
						if (exp_q.size() == 0) begin
							@(negedge clk);
							check_memory();
							done = 1'b1;
						end
					end
				end
			end
		end
	end

	initial begin
		void'($urandom(32'hc7fd));
		resetn = 1'b0;
		build_program();
		limit = 5 * n_exec + 200;
		repeat (10) @(negedge clk);
		resetn = 1'b1;
		while (!done && cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		if (!done) begin
			timeouts = 1;
			$display("timeout: only %0d of %0d write-backs seen after %0d cycles",
				compared, total, cycles);
		end
		total_errs = errors + timeouts + UUT.chk.fail_count;
		$display("errors %0d, timeouts %0d, assertion failures %0d, write-backs %0d of %0d",
			errors, timeouts, UUT.chk.fail_count, compared, total);
		if (total_errs == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

/* mango.f */
mango_pkg.sv
mango_alu.sv
mango_decode.sv
mango_regfile.sv
mango_lsu.sv
mango_core.sv
mycpu_top.sv
mycpu_checker.sv
tb_mycpu.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_mycpu -f mango.f --Mdir obj_dir -o tb_mycpu

./obj_dir/tb_mycpu +verilator+error+limit+1000 | tee sim.log

if grep -q '^TB PASSED$' sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
